// File: hw/regRead_settings.svh
`ifndef REGREAD_SETTINGS_SVH
`define REGREAD_SETTINGS_SVH

// integer register width
`define XLEN 32

// floating-point register width, wide enough for double precision
`define FLEN 64

// both register files hold the same number of entries
`define NUM_REGS 32

// register specifier width in the instruction encoding
`define REG_ADDR_W 5

`endif

// File: hw/pipeTypesPkg.sv
`default_nettype none

`include "regRead_settings.svh"

package pipeTypesPkg;

    // plain vectors with a meaning of their own
    typedef logic [`REG_ADDR_W-1:0] regAddrT;
    typedef logic [`XLEN-1:0]       intWordT;
    typedef logic [`FLEN-1:0]       fpWordT;
    typedef logic [31:0]            insnT;
    typedef logic [31:0]            pcT;
    typedef logic [11:0]            csrAddrT;

    // illegal instruction cause code
    localparam logic [3:0] CAUSE_ILLEGAL_INSN = 4'd2;

    // coarse opcode class, the execute stage refines it from insn
    typedef enum logic [3:0] {
        OP_INT_REG,
        OP_INT_IMM,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH,
        OP_FP,
        OP_FP_FMA,
        OP_FP_LOAD,
        OP_FP_STORE,
        OP_NONE
    } opClassT;

    typedef struct packed {
        opClassT opClass;
        regAddrT rd;
        regAddrT rs1;
        regAddrT rs2;
        regAddrT rs3;
    } opT;

    typedef struct packed {
        logic       valid;
        logic [3:0] cause;
        logic [31:0] value;
    } trapInfoT;

    typedef struct packed {
        logic     valid;
        opT       op;
        pcT       pc;
        insnT     insn;
        csrAddrT  csrAddr;
        trapInfoT trapInfo;
    } decodeOutT;

    // bundle handed to execute, operands already read
    typedef struct packed {
        logic     valid;
        opT       op;
        pcT       pc;
        insnT     insn;
        csrAddrT  csrAddr;
        intWordT  srcIntRegValue1;
        intWordT  srcIntRegValue2;
        fpWordT   srcFpRegValue1;
        fpWordT   srcFpRegValue2;
        fpWordT   srcFpRegValue3;
        trapInfoT trapInfo;
    } regReadOutT;

    typedef struct packed {
        logic    enable;
        regAddrT addr;
        intWordT value;
    } intWriteT;

    typedef struct packed {
        logic    enable;
        regAddrT addr;
        fpWordT  value;
    } fpWriteT;

endpackage

`default_nettype wire

// File: hw/decodeStage.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStage import pipeTypesPkg::*; (
    input  wire logic      clk,
    input  wire logic      rstN,
    input  wire logic      stall,
    input  wire logic      flush,
    input  wire logic      insnValid,
    input  wire insnT      insn,
    input  wire pcT        pc,
    output decodeOutT      decoded
);

    // major opcodes, insn[6:0]
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_STORE_FP = 7'b0100111;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_MADD     = 7'b1000011;
    localparam logic [6:0] OPC_MSUB     = 7'b1000111;
    localparam logic [6:0] OPC_NMSUB    = 7'b1001011;
    localparam logic [6:0] OPC_NMADD    = 7'b1001111;
    localparam logic [6:0] OPC_OP_FP    = 7'b1010011;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;

    logic [6:0] opcode;
    opClassT    opClass;
    decodeOutT  nextDecoded;

    assign opcode = insn[6:0];

    always_comb begin
        case (opcode)
            OPC_OP:       opClass = OP_INT_REG;
            OPC_OP_IMM:   opClass = OP_INT_IMM;
            OPC_LOAD:     opClass = OP_LOAD;
            OPC_STORE:    opClass = OP_STORE;
            OPC_BRANCH:   opClass = OP_BRANCH;
            OPC_OP_FP:    opClass = OP_FP;
            OPC_MADD, OPC_MSUB, OPC_NMSUB, OPC_NMADD: begin
                opClass = OP_FP_FMA;
            end
            OPC_LOAD_FP:  opClass = OP_FP_LOAD;
            OPC_STORE_FP: opClass = OP_FP_STORE;
            // anything else is treated as illegal
            default:      opClass = OP_NONE;
        endcase
    end

    // an empty slot carries all zeros so downstream sees a clean bubble
    always_comb begin
        nextDecoded = '0;
        if (insnValid) begin
            nextDecoded.valid      = 1'b1;
            nextDecoded.op.opClass = opClass;
            nextDecoded.op.rd      = insn[11:7];
            nextDecoded.op.rs1     = insn[19:15];
            nextDecoded.op.rs2     = insn[24:20];
            nextDecoded.op.rs3     = insn[31:27];
            nextDecoded.pc         = pc;
            nextDecoded.insn       = insn;
            // only carried along, no CSR access here
            nextDecoded.csrAddr    = insn[31:20];
            if (opClass == OP_NONE) begin
                nextDecoded.trapInfo.valid = 1'b1;
                nextDecoded.trapInfo.cause = CAUSE_ILLEGAL_INSN;
                nextDecoded.trapInfo.value = insn;
            end
        end
    end

    // flush wins over stall, stall holds the slot
    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            decoded <= '0;
        end else if (!stall) begin
            decoded <= nextDecoded;
        end
    end

endmodule

`default_nettype wire

// File: hw/intRegFile.sv
`timescale 1ns/10ps
`default_nettype none

`include "regRead_settings.svh"

module intRegFile import pipeTypesPkg::*; (
    input  wire logic     clk,
    input  wire logic     rstN,
    input  wire regAddrT  readAddr1,
    input  wire regAddrT  readAddr2,
    input  wire intWriteT write,
    output intWordT       readValue1,
    output intWordT       readValue2
);

    intWordT regs [`NUM_REGS];

    // x0 reads as zero, a same-cycle write to the address is forwarded
    function automatic intWordT readPort(regAddrT addr);
        intWordT value;
        if (addr == '0) begin
            value = '0;
        end else if (write.enable && (write.addr == addr)) begin
            value = write.value;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        readValue1 = readPort(readAddr1);
        readValue2 = readPort(readAddr2);
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write.enable && (write.addr != '0)) begin
            regs[write.addr] <= write.value;
        end
    end

endmodule

`default_nettype wire

// File: hw/fpRegFile.sv
`timescale 1ns/10ps
`default_nettype none

`include "regRead_settings.svh"

module fpRegFile import pipeTypesPkg::*; (
    input  wire logic    clk,
    input  wire logic    rstN,
    input  wire regAddrT readAddr1,
    input  wire regAddrT readAddr2,
    input  wire regAddrT readAddr3,
    input  wire fpWriteT write,
    output fpWordT       readValue1,
    output fpWordT       readValue2,
    output fpWordT       readValue3
);

    fpWordT regs [`NUM_REGS];

    // f0 is a normal register, only the write bypass applies
    function automatic fpWordT readPort(regAddrT addr);
        fpWordT value;
        if (write.enable && (write.addr == addr)) begin
            value = write.value;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        readValue1 = readPort(readAddr1);
        readValue2 = readPort(readAddr2);
        readValue3 = readPort(readAddr3);
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write.enable) begin
            regs[write.addr] <= write.value;
        end
    end

endmodule

`default_nettype wire

// File: hw/regReadStage.sv
`timescale 1ns/10ps
`default_nettype none

module regReadStage import pipeTypesPkg::*; (
    input  wire logic      clk,
    input  wire logic      rstN,
    input  wire logic      stall,
    input  wire logic      flush,
    input  wire decodeOutT decoded,
    input  wire intWordT   intReadValue1,
    input  wire intWordT   intReadValue2,
    input  wire fpWordT    fpReadValue1,
    input  wire fpWordT    fpReadValue2,
    input  wire fpWordT    fpReadValue3,
    output regAddrT        intReadAddr1,
    output regAddrT        intReadAddr2,
    output regAddrT        fpReadAddr1,
    output regAddrT        fpReadAddr2,
    output regAddrT        fpReadAddr3,
    output regReadOutT     issued
);

    regReadOutT nextIssued;

    // both files are addressed for every instruction, execute picks the operands
    assign intReadAddr1 = decoded.op.rs1;
    assign intReadAddr2 = decoded.op.rs2;
    assign fpReadAddr1  = decoded.op.rs1;
    assign fpReadAddr2  = decoded.op.rs2;
    // rs3 only exists in the FMA encodings
    assign fpReadAddr3  = decoded.op.rs3;

    always_comb begin
        nextIssued.valid           = decoded.valid;
        nextIssued.op              = decoded.op;
        nextIssued.pc              = decoded.pc;
        nextIssued.insn            = decoded.insn;
        nextIssued.csrAddr         = decoded.csrAddr;
        nextIssued.srcIntRegValue1 = intReadValue1;
        nextIssued.srcIntRegValue2 = intReadValue2;
        nextIssued.srcFpRegValue1  = fpReadValue1;
        nextIssued.srcFpRegValue2  = fpReadValue2;
        nextIssued.srcFpRegValue3  = fpReadValue3;
        nextIssued.trapInfo        = decoded.trapInfo;
    end

    // operands are captured at the same edge as the control fields
    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            issued <= '0;
        end else if (!stall) begin
            issued <= nextIssued;
        end
    end

endmodule

`default_nettype wire

// File: hw/frontReadPipe.sv
`timescale 1ns/10ps
`default_nettype none

module frontReadPipe import pipeTypesPkg::*; (
    input  wire logic     clk,
    input  wire logic     rstN,
    input  wire logic     stall,
    input  wire logic     flush,
    input  wire logic     insnValid,
    input  wire insnT     insn,
    input  wire pcT       pc,
    input  wire intWriteT intWrite,
    input  wire fpWriteT  fpWrite,
    output regReadOutT    issued
);

    decodeOutT decoded;

    regAddrT intReadAddr1;
    regAddrT intReadAddr2;
    regAddrT fpReadAddr1;
    regAddrT fpReadAddr2;
    regAddrT fpReadAddr3;

    intWordT intReadValue1;
    intWordT intReadValue2;
    fpWordT  fpReadValue1;
    fpWordT  fpReadValue2;
    fpWordT  fpReadValue3;

    decodeStage i_decodeStage (
        .clk       (clk),
        .rstN      (rstN),
        .stall     (stall),
        .flush     (flush),
        .insnValid (insnValid),
        .insn      (insn),
        .pc        (pc),
        .decoded   (decoded)
    );

    // writeback stands in through the two write ports
    intRegFile i_intRegFile (
        .clk        (clk),
        .rstN       (rstN),
        .readAddr1  (intReadAddr1),
        .readAddr2  (intReadAddr2),
        .write      (intWrite),
        .readValue1 (intReadValue1),
        .readValue2 (intReadValue2)
    );

    fpRegFile i_fpRegFile (
        .clk        (clk),
        .rstN       (rstN),
        .readAddr1  (fpReadAddr1),
        .readAddr2  (fpReadAddr2),
        .readAddr3  (fpReadAddr3),
        .write      (fpWrite),
        .readValue1 (fpReadValue1),
        .readValue2 (fpReadValue2),
        .readValue3 (fpReadValue3)
    );

    regReadStage i_regReadStage (
        .clk           (clk),
        .rstN          (rstN),
        .stall         (stall),
        .flush         (flush),
        .decoded       (decoded),
        .intReadValue1 (intReadValue1),
        .intReadValue2 (intReadValue2),
        .fpReadValue1  (fpReadValue1),
        .fpReadValue2  (fpReadValue2),
        .fpReadValue3  (fpReadValue3),
        .intReadAddr1  (intReadAddr1),
        .intReadAddr2  (intReadAddr2),
        .fpReadAddr1   (fpReadAddr1),
        .fpReadAddr2   (fpReadAddr2),
        .fpReadAddr3   (fpReadAddr3),
        .issued        (issued)
    );

endmodule

`default_nettype wire

// File: test/tbClock.sv
`timescale 1ns/10ps
`default_nettype none

module tbClock #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    // free running, the testbench ends the run with $finish
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: test/tbFrontReadPipe.sv
`timescale 1ns/10ps
`default_nettype none

module tbFrontReadPipe import pipeTypesPkg::*; ();

    // one table row per clock cycle
    typedef struct packed {
        logic    insnValid;
        insnT    insn;
        logic    stall;
        logic    flush;
        logic    intWe;
        regAddrT intAddr;
        logic    fpWe;
        regAddrT fpAddr;
        opClassT expClass;
    } stimT;

    logic       clk;
    logic       rstN;
    logic       stall;
    logic       flush;
    logic       insnValid;
    insnT       insn;
    pcT         pc;
    intWriteT   intWrite;
    fpWriteT    fpWrite;
    regReadOutT issued;

    // reference copies of both register files
    intWordT     intModel [32];
    fpWordT      fpModel [32];
    logic [31:0] lcgState;
    int          driveCount;
    stimT        stimTable [$];

    // expected contents of the two pipeline slots
    logic       decValid;
    stimT       decStim;
    pcT         decPc;
    logic       issValid;
    regReadOutT expIss;

    tbClock #(.PERIOD_NS(4)) clockGen (.clk(clk));

    frontReadPipe i_frontReadPipe (
        .clk       (clk),
        .rstN      (rstN),
        .stall     (stall),
        .flush     (flush),
        .insnValid (insnValid),
        .insn      (insn),
        .pc        (pc),
        .intWrite  (intWrite),
        .fpWrite   (fpWrite),
        .issued    (issued)
    );

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    // R4 layout, fields that an opcode does not use are simply ignored
    function automatic insnT encode(logic [6:0] opcode, regAddrT rd, regAddrT rs1,
                                    regAddrT rs2, regAddrT rs3);
        return {rs3, 2'b00, rs2, rs1, 3'b000, rd, opcode};
    endfunction

    function automatic stimT insnEntry(insnT code, opClassT expClass);
        stimT s;
        s = '0;
        s.insnValid = 1'b1;
        s.insn = code;
        s.expClass = expClass;
        return s;
    endfunction

    task automatic addInsn(logic [6:0] opcode, regAddrT rd, regAddrT rs1, regAddrT rs2,
                           regAddrT rs3, opClassT expClass);
        stimTable.push_back(insnEntry(encode(opcode, rd, rs1, rs2, rs3), expClass));
    endtask

    // fields follow the instruction, operands come from the model files
    function automatic regReadOutT buildIssued(stimT s, pcT p);
        regReadOutT r;
        r = '0;
        r.valid = 1'b1;
        r.op.opClass = s.expClass;
        r.op.rd = s.insn[11:7];
        r.op.rs1 = s.insn[19:15];
        r.op.rs2 = s.insn[24:20];
        r.op.rs3 = s.insn[31:27];
        r.pc = p;
        r.insn = s.insn;
        r.csrAddr = s.insn[31:20];
        r.srcIntRegValue1 = intModel[r.op.rs1];
        r.srcIntRegValue2 = intModel[r.op.rs2];
        r.srcFpRegValue1 = fpModel[r.op.rs1];
        r.srcFpRegValue2 = fpModel[r.op.rs2];
        r.srcFpRegValue3 = fpModel[r.op.rs3];
        // unknown opcode means illegal instruction, cause 2
        if (s.expClass == OP_NONE) begin
            r.trapInfo.valid = 1'b1;
            r.trapInfo.cause = 4'd2;
            r.trapInfo.value = s.insn;
        end
        return r;
    endfunction

    task automatic failRun(string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkValue(string name, logic [63:0] got, logic [63:0] exp);
        assert (got === exp) else begin
            failRun($sformatf("error %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic checkIssued(logic flushed);
        if (flushed) begin
            assert (issued === '0) else begin
                failRun("issued still holds data after a flush");
            end
        end
        checkValue("issued.valid", 64'(issued.valid), 64'(issValid));
        if (issValid) begin
            checkValue("issued.op", 64'(issued.op), 64'(expIss.op));
            checkValue("issued.pc", 64'(issued.pc), 64'(expIss.pc));
            checkValue("issued.insn", 64'(issued.insn), 64'(expIss.insn));
            checkValue("issued.csrAddr", 64'(issued.csrAddr), 64'(expIss.csrAddr));
            checkValue("issued.srcIntRegValue1", 64'(issued.srcIntRegValue1),
                       64'(expIss.srcIntRegValue1));
            checkValue("issued.srcIntRegValue2", 64'(issued.srcIntRegValue2),
                       64'(expIss.srcIntRegValue2));
            checkValue("issued.srcFpRegValue1", issued.srcFpRegValue1, expIss.srcFpRegValue1);
            checkValue("issued.srcFpRegValue2", issued.srcFpRegValue2, expIss.srcFpRegValue2);
            checkValue("issued.srcFpRegValue3", issued.srcFpRegValue3, expIss.srcFpRegValue3);
            checkValue("issued.trapInfo", 64'(issued.trapInfo), 64'(expIss.trapInfo));
        end
    endtask

    // drive one row, advance the reference at the edge, then check
    task automatic stepCycle(stimT s);
        intWordT intValue;
        fpWordT  fpValue;
        pcT      curPc;
        intValue = nextRand();
        fpValue = {nextRand(), nextRand()};
        curPc = 32'h1000 + 32'(driveCount) * 32'd4;
        driveCount++;
        insnValid = s.insnValid;
        insn = s.insn;
        pc = curPc;
        stall = s.stall;
        flush = s.flush;
        intWrite = '{enable: s.intWe, addr: s.intAddr, value: intValue};
        fpWrite = '{enable: s.fpWe, addr: s.fpAddr, value: fpValue};
        @(posedge clk);
        // write first, so the instruction on decoded sees the new value
        if (s.intWe && (s.intAddr != '0)) begin
            intModel[s.intAddr] = intValue;
        end
        if (s.fpWe) begin
            fpModel[s.fpAddr] = fpValue;
        end
        if (s.flush) begin
            decValid = 1'b0;
            issValid = 1'b0;
        end else if (!s.stall) begin
            issValid = decValid;
            if (decValid) begin
                expIss = buildIssued(decStim, decPc);
            end
            decValid = s.insnValid;
            decStim = s;
            decPc = curPc;
        end
        #1;
        checkIssued(s.flush);
    endtask

    task automatic buildTable();
        stimT e;
        // R-type and FMA stream, plus one of every other class
        addInsn(7'b0110011, 5'd3, 5'd1, 5'd2, 5'd0, OP_INT_REG);
        addInsn(7'b1000011, 5'd4, 5'd7, 5'd8, 5'd9, OP_FP_FMA);
        // x0 was written during the fill and must still read zero
        addInsn(7'b0110011, 5'd5, 5'd0, 5'd0, 5'd0, OP_INT_REG);
        addInsn(7'b1000111, 5'd10, 5'd11, 5'd12, 5'd13, OP_FP_FMA);
        addInsn(7'b1001011, 5'd14, 5'd15, 5'd16, 5'd17, OP_FP_FMA);
        addInsn(7'b1001111, 5'd18, 5'd31, 5'd30, 5'd29, OP_FP_FMA);
        addInsn(7'b1010011, 5'd1, 5'd2, 5'd3, 5'd0, OP_FP);
        addInsn(7'b0010011, 5'd6, 5'd20, 5'd21, 5'd0, OP_INT_IMM);
        addInsn(7'b0000011, 5'd7, 5'd22, 5'd0, 5'd0, OP_LOAD);
        addInsn(7'b0100011, 5'd0, 5'd23, 5'd24, 5'd0, OP_STORE);
        addInsn(7'b1100011, 5'd0, 5'd25, 5'd26, 5'd0, OP_BRANCH);
        addInsn(7'b0000111, 5'd8, 5'd27, 5'd0, 5'd0, OP_FP_LOAD);
        addInsn(7'b0100111, 5'd0, 5'd28, 5'd29, 5'd0, OP_FP_STORE);
        // bypass, x12 and f14 are written while the FMA sits on decoded
        addInsn(7'b1000011, 5'd9, 5'd12, 5'd13, 5'd14, OP_FP_FMA);
        e = insnEntry(encode(7'b0110011, 5'd2, 5'd12, 5'd0, 5'd0), OP_INT_REG);
        e.intWe = 1'b1;
        e.intAddr = 5'd12;
        e.fpWe = 1'b1;
        e.fpAddr = 5'd14;
        stimTable.push_back(e);
        addInsn(7'b1111111, 5'd1, 5'd2, 5'd3, 5'd4, OP_NONE);
        addInsn(7'b0001011, 5'd5, 5'd6, 5'd7, 5'd8, OP_NONE);
        // stall for three cycles, offered instructions are dropped, x3 keeps changing
        addInsn(7'b0110011, 5'd11, 5'd3, 5'd4, 5'd0, OP_INT_REG);
        addInsn(7'b1000011, 5'd12, 5'd5, 5'd6, 5'd7, OP_FP_FMA);
        e = insnEntry(encode(7'b1100011, 5'd0, 5'd8, 5'd9, 5'd0), OP_BRANCH);
        e.stall = 1'b1;
        e.intWe = 1'b1;
        e.intAddr = 5'd3;
        repeat (3) stimTable.push_back(e);
        addInsn(7'b0110011, 5'd13, 5'd3, 5'd5, 5'd0, OP_INT_REG);
        // flush with stall in the same cycle drops both slots
        addInsn(7'b0110011, 5'd14, 5'd1, 5'd2, 5'd0, OP_INT_REG);
        addInsn(7'b1010011, 5'd15, 5'd3, 5'd4, 5'd0, OP_FP);
        e = insnEntry(encode(7'b0000011, 5'd16, 5'd5, 5'd0, 5'd0), OP_LOAD);
        e.flush = 1'b1;
        e.stall = 1'b1;
        stimTable.push_back(e);
        addInsn(7'b0100011, 5'd0, 5'd6, 5'd7, 5'd0, OP_STORE);
        addInsn(7'b1000111, 5'd17, 5'd8, 5'd9, 5'd10, OP_FP_FMA);
    endtask

    initial begin
        stimT e;
        int   waited;
        rstN = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        insnValid = 1'b0;
        insn = '0;
        pc = '0;
        intWrite = '0;
        fpWrite = '0;
        lcgState = 32'd4377;
        driveCount = 0;
        decValid = 1'b0;
        decStim = '0;
        decPc = '0;
        issValid = 1'b0;
        expIss = '0;
        for (int i = 0; i < 32; i++) begin
            intModel[i] = '0;
            fpModel[i] = '0;
        end
        buildTable();
        repeat (8) @(posedge clk);
        #1;
        rstN = 1'b1;
        assert (issued === '0) else begin
            failRun("issued is not all zero after reset");
        end
        // fill every register of both files, x0 included
        for (int i = 0; i < 32; i++) begin
            e = '0;
            e.intWe = 1'b1;
            e.intAddr = regAddrT'(i);
            e.fpWe = 1'b1;
            e.fpAddr = regAddrT'(i);
            stepCycle(e);
        end
        foreach (stimTable[k]) begin
            stepCycle(stimTable[k]);
        end
        // idle until the last instruction has left issued
        waited = 0;
        e = '0;
        while (decValid || issValid) begin
            if (waited == 10) begin
                failRun("timeout while waiting for the pipeline to drain");
            end
            stepCycle(e);
            waited++;
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+hw
hw/pipeTypesPkg.sv
hw/decodeStage.sv
hw/intRegFile.sv
hw/fpRegFile.sv
hw/regReadStage.sv
hw/frontReadPipe.sv
test/tbClock.sv
test/tbFrontReadPipe.sv

// File: Makefile
TOP = tbFrontReadPipe

all: run

compile:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir -o simv

run: compile
	./obj_dir/simv | tee run.log
	grep -q ">>> PASS" run.log

clean:
	rm -rf obj_dir run.log

.PHONY: all compile run clean
